// ==== rtl/ethFramePkg.sv ====
package ethFramePkg;

   // GMII framing bytes ahead of the frame body
   localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
   localparam logic [7:0] SFD_BYTE = 8'hD5;

   // addresses and ports this board answers to
   localparam logic [47:0] BOARD_MAC = 48'h0080_55ec_0078;
   localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
   localparam logic [7:0] IP_PROTO_UDP = 8'h11;
   localparam logic [31:0] BOARD_IP = {8'd192, 8'd168, 8'd46, 8'd120};
   localparam logic [15:0] CMD_PORT = 16'd2007;

   // byte index width, saturates at the top value
   localparam int FRAME_IDX_W = 7;

   // offsets from the first destination MAC byte
   localparam logic [FRAME_IDX_W-1:0] OFS_ETHERTYPE = 7'd12;
   localparam logic [FRAME_IDX_W-1:0] OFS_PROTO = 7'd23;
   localparam logic [FRAME_IDX_W-1:0] OFS_DST_IP = 7'd30;
   localparam logic [FRAME_IDX_W-1:0] OFS_DST_PORT = 7'd36;
   localparam logic [FRAME_IDX_W-1:0] OFS_CMD = 7'd42;

   // CRC-32, register kept in normal bit order
   localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;
   localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;
   // value left once the FCS bytes went through the register
   localparam logic [31:0] CRC_RESIDUE = 32'hC704_DD7B;
   localparam int CRC_BYTES = 4;

endpackage

// ==== rtl/regCmdPkg.sv ====
package regCmdPkg;

   // register store
   localparam logic [6:0] REG_COUNT = 7'd64;
   localparam int REG_IDX_W = 6;
   localparam int ADDR_W = 36;
   localparam int DATA_W = 64;
   localparam int DATA_BYTES = DATA_W / 8;
   localparam logic [7:0] MAX_READ_WORDS = 8'd8;

   // reply path
   localparam int REPLY_DEPTH = 16;
   localparam int REPLY_PTR_W = $clog2(REPLY_DEPTH);
   localparam int REPLY_CREDITS = 4;
   localparam int CREDIT_W = $clog2(REPLY_CREDITS + 1);

   // command header layout
   localparam int CMD_HDR_BYTES = 10;
   localparam int FLAG_WRITE = 0;

   typedef logic [ADDR_W-1:0] regAddrT;
   typedef logic [DATA_W-1:0] regDataT;

   // byteView[0] is the first byte on the wire, so the
   // little-endian address lands as one plain field
   typedef union packed {
      logic [CMD_HDR_BYTES-1:0][7:0] byteView;
      struct packed {
         logic [8*CMD_HDR_BYTES-ADDR_W-17:0] unused;
         regAddrT addr;
         logic [7:0] count;
         logic [7:0] flags;
      } fieldView;
   } cmdHeaderU;

endpackage

// ==== rtl/gmiiFrameRx.sv ====
module gmiiFrameRx import ethFramePkg::*;
(
   input  logic                   PHY_RXCLK,
   input  logic                   rst,
   input  logic [7:0]             PHY_RXD,
   input  logic                   PHY_RXCTL_RXDV,
   input  logic                   PHY_RXER,
   output logic [7:0]             frameByte,
   output logic                   byteValid,
   output logic [FRAME_IDX_W-1:0] byteIdx,
   output logic                   frameStart,
   output logic                   frameEnd,
   output logic                   frameErr
);

   // one-hot state, both low is idle
   logic inPreamble;
   logic inBody;
   // index for the next body byte
   logic [FRAME_IDX_W-1:0] nextIdx;

   always_ff @(posedge PHY_RXCLK)
   begin
      if (rst)
      begin
         inPreamble <= 1'b0;
         inBody <= 1'b0;
         byteValid <= 1'b0;
         frameStart <= 1'b0;
         frameEnd <= 1'b0;
         frameErr <= 1'b0;
      end
      else
      begin
         byteValid <= 1'b0;
         frameStart <= 1'b0;
         frameEnd <= 1'b0;
         if (inBody)
         begin
            if (PHY_RXCTL_RXDV)
            begin
               byteValid <= 1'b1;
               frameErr <= frameErr | PHY_RXER;
            end
            else
            begin
               inBody <= 1'b0;
               frameEnd <= 1'b1;
            end
         end
         else if (inPreamble && PHY_RXCTL_RXDV && PHY_RXD == SFD_BYTE)
         begin
            inPreamble <= 1'b0;
            inBody <= 1'b1;
            frameStart <= 1'b1;
            frameErr <= PHY_RXER;
         end
         else
            // any other byte restarts the preamble search
            inPreamble <= PHY_RXCTL_RXDV && PHY_RXD == PREAMBLE_BYTE;
      end
   end

   always_ff @(posedge PHY_RXCLK)
   begin
      if (inBody && PHY_RXCTL_RXDV)
      begin
         frameByte <= PHY_RXD;
         byteIdx <= nextIdx;
         if (nextIdx != '1)
            nextIdx <= nextIdx + 1'b1;
      end
      else if (!inBody)
         nextIdx <= '0;
   end

endmodule

// ==== rtl/ethCrcCheck.sv ====
module ethCrcCheck import ethFramePkg::*;
(
   input  logic       PHY_RXCLK,
   input  logic       rst,
   input  logic [7:0] frameByte,
   input  logic       byteValid,
   input  logic       frameStart,
   input  logic       frameEnd,
   output logic       crcOk
);

   logic [31:0] crcReg;

   // one byte through the CRC, bit 0 goes first as on the wire
   function automatic logic [31:0] crcNext(input logic [31:0] crc, input logic [7:0] data);
      logic [31:0] c;
      c = crc;
      for (int i = 0; i < 8; i++)
      begin
         if (c[31] ^ data[i])
            c = {c[30:0], 1'b0} ^ CRC_POLY;
         else
            c = {c[30:0], 1'b0};
      end
      return c;
   endfunction

   always_ff @(posedge PHY_RXCLK)
   begin
      if (rst)
         crcReg <= CRC_INIT;
      else if (frameStart)
         crcReg <= CRC_INIT;
      else if (byteValid)
         crcReg <= crcNext(crcReg, frameByte);
   end

   // FCS bytes included, so a clean frame leaves the fixed residue
   assign crcOk = frameEnd && crcReg == CRC_RESIDUE;

endmodule

// ==== rtl/udpCmdParser.sv ====
module udpCmdParser import ethFramePkg::*, regCmdPkg::*;
(
   input  logic                   PHY_RXCLK,
   input  logic                   rst,
   input  logic [7:0]             frameByte,
   input  logic                   byteValid,
   input  logic [FRAME_IDX_W-1:0] byteIdx,
   input  logic                   frameStart,
   input  logic                   frameEnd,
   input  logic                   frameErr,
   input  logic                   crcOk,
   input  logic                   regBusy,
   output logic                   cmdValid,
   output logic                   cmdWrite,
   output regAddrT                cmdAddr,
   output logic [7:0]             cmdCount,
   output regDataT                cmdData
);

   // header constants seen as bytes in wire order
   logic [0:5][7:0] macBytes;
   logic [0:1][7:0] typeBytes;
   logic [0:3][7:0] ipBytes;
   logic [0:1][7:0] portBytes;

   // positions relative to each field, wrap keeps them unsigned
   logic [FRAME_IDX_W-1:0] relType;
   logic [FRAME_IDX_W-1:0] relIp;
   logic [FRAME_IDX_W-1:0] relPort;
   logic [FRAME_IDX_W-1:0] relCmd;
   logic [FRAME_IDX_W-1:0] relData;

   logic [7:0] expByte;
   logic expCheck;
   logic matchOk;
   logic [FRAME_IDX_W-1:0] lastIdx;
   logic [FRAME_IDX_W-1:0] minLast;
   logic countOk;
   cmdHeaderU cmdHdr;
   regDataT dataWord;

   assign macBytes = BOARD_MAC;
   assign typeBytes = ETHERTYPE_IPV4;
   assign ipBytes = BOARD_IP;
   assign portBytes = CMD_PORT;

   assign relType = byteIdx - OFS_ETHERTYPE;
   assign relIp = byteIdx - OFS_DST_IP;
   assign relPort = byteIdx - OFS_DST_PORT;
   assign relCmd = byteIdx - OFS_CMD;
   assign relData = relCmd - FRAME_IDX_W'(CMD_HDR_BYTES);

   // expected value for the byte now on frameByte
   always_comb
   begin
      expCheck = 1'b1;
      expByte = 8'h00;
      if (byteIdx <= 7'd5)
         expByte = macBytes[byteIdx[2:0]];
      else if (relType < 7'd2)
         expByte = typeBytes[relType[0]];
      else if (byteIdx == OFS_PROTO)
         expByte = IP_PROTO_UDP;
      else if (relIp < 7'd4)
         expByte = ipBytes[relIp[1:0]];
      else if (relPort < 7'd2)
         expByte = portBytes[relPort[0]];
      else
         expCheck = 1'b0;
   end

   assign cmdWrite = cmdHdr.fieldView.flags[FLAG_WRITE];
   assign cmdAddr = cmdHdr.fieldView.addr;
   assign cmdCount = cmdHdr.fieldView.count;
   assign cmdData = dataWord;

   // last byte index must reach past the command and the FCS
   assign minLast = cmdWrite ?
      OFS_CMD + FRAME_IDX_W'(CMD_HDR_BYTES + DATA_BYTES + CRC_BYTES - 1) :
      OFS_CMD + FRAME_IDX_W'(CMD_HDR_BYTES + CRC_BYTES - 1);

   assign countOk = cmdWrite ? cmdCount == 8'd1 :
      cmdCount != 8'd0 && cmdCount <= MAX_READ_WORDS;

   always_ff @(posedge PHY_RXCLK)
   begin
      if (rst)
      begin
         matchOk <= 1'b0;
         cmdValid <= 1'b0;
      end
      else
      begin
         cmdValid <= frameEnd && matchOk && crcOk && !frameErr &&
            lastIdx >= minLast && countOk && !regBusy;
         if (frameStart)
            matchOk <= 1'b1;
         else if (byteValid && expCheck && frameByte != expByte)
            matchOk <= 1'b0;
      end
   end

   // header then data word, both shifted in from the top
   always_ff @(posedge PHY_RXCLK)
   begin
      if (byteValid)
      begin
         lastIdx <= byteIdx;
         if (relCmd < FRAME_IDX_W'(CMD_HDR_BYTES))
            cmdHdr.byteView <= {frameByte, cmdHdr.byteView[CMD_HDR_BYTES-1:1]};
         else if (relData < FRAME_IDX_W'(DATA_BYTES))
            dataWord <= {frameByte, dataWord[DATA_W-1:8]};
      end
   end

endmodule

// ==== rtl/regBank.sv ====
module regBank import regCmdPkg::*;
(
   input  logic       PHY_RXCLK,
   input  logic       rst,
   input  logic       cmdValid,
   input  logic       cmdWrite,
   input  regAddrT    cmdAddr,
   input  logic [7:0] cmdCount,
   input  regDataT    cmdData,
   input  logic       queueFull,
   output logic       regBusy,
   output logic       pushValid,
   output regAddrT    pushAddr,
   output regDataT    pushData
);

   regDataT regMem [REG_COUNT];
   regAddrT burstAddr;
   logic [7:0] burstLeft;

   // upper address bits clear means a real register
   function automatic logic inRange(input regAddrT addr);
      return addr[ADDR_W-1:REG_IDX_W] == '0;
   endfunction

   assign pushValid = regBusy && !queueFull;
   assign pushAddr = burstAddr;
   assign pushData = inRange(burstAddr) ? regMem[burstAddr[REG_IDX_W-1:0]] : '0;

   always_ff @(posedge PHY_RXCLK)
   begin
      if (rst)
      begin
         regMem <= '{default: '0};
         regBusy <= 1'b0;
      end
      else
      begin
         if (cmdValid && cmdWrite && inRange(cmdAddr))
            regMem[cmdAddr[REG_IDX_W-1:0]] <= cmdData;
         if (cmdValid && !cmdWrite)
            regBusy <= 1'b1;
         else if (pushValid && burstLeft == 8'd1)
            regBusy <= 1'b0;
      end
   end

   // burst walks consecutive addresses, one per accepted push
   always_ff @(posedge PHY_RXCLK)
   begin
      if (cmdValid && !cmdWrite)
      begin
         burstAddr <= cmdAddr;
         burstLeft <= cmdCount;
      end
      else if (pushValid)
      begin
         burstAddr <= burstAddr + 1'b1;
         burstLeft <= burstLeft - 1'b1;
      end
   end

endmodule

// ==== rtl/replyCreditQueue.sv ====
module replyCreditQueue import regCmdPkg::*;
(
   input  logic    PHY_RXCLK,
   input  logic    rst,
   input  logic    pushValid,
   input  regAddrT pushAddr,
   input  regDataT pushData,
   output logic    queueFull,
   input  logic    replyCredit,
   output logic    replyValid,
   output regAddrT replyAddr,
   output regDataT replyData
);

   regAddrT addrMem [REPLY_DEPTH];
   regDataT dataMem [REPLY_DEPTH];
   logic [REPLY_PTR_W-1:0] wrPtr;
   logic [REPLY_PTR_W-1:0] rdPtr;
   logic [REPLY_PTR_W:0] fillCnt;
   logic [CREDIT_W-1:0] creditCnt;
   logic pushEn;

   // top bit of the fill count only sets when every slot is taken
   assign queueFull = fillCnt[REPLY_PTR_W];
   assign pushEn = pushValid && !queueFull;

   // a word leaves only with a credit in hand
   assign replyValid = fillCnt != '0 && creditCnt != '0;
   assign replyAddr = addrMem[rdPtr];
   assign replyData = dataMem[rdPtr];

   always_ff @(posedge PHY_RXCLK)
   begin
      if (pushEn)
      begin
         addrMem[wrPtr] <= pushAddr;
         dataMem[wrPtr] <= pushData;
      end
   end

   always_ff @(posedge PHY_RXCLK)
   begin
      if (rst)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
         fillCnt <= '0;
         creditCnt <= CREDIT_W'(REPLY_CREDITS);
      end
      else
      begin
         if (pushEn)
            wrPtr <= wrPtr + 1'b1;
         if (replyValid)
            rdPtr <= rdPtr + 1'b1;
         fillCnt <= fillCnt + (REPLY_PTR_W+1)'(pushEn) - (REPLY_PTR_W+1)'(replyValid);
         // returned credit counts from the next cycle
         creditCnt <= creditCnt + CREDIT_W'(replyCredit) - CREDIT_W'(replyValid);
      end
   end

endmodule

// ==== rtl/rtfCmdRx.sv ====
module rtfCmdRx import ethFramePkg::*, regCmdPkg::*;
(
   input  logic       PHY_RXCLK,
   input  logic       rst,
   input  logic [7:0] PHY_RXD,
   input  logic       PHY_RXCTL_RXDV,
   input  logic       PHY_RXER,
   input  logic       replyCredit,
   output logic       replyValid,
   output regAddrT    replyAddr,
   output regDataT    replyData
);

   // receive chain
   logic [7:0] frameByte;
   logic byteValid;
   logic [FRAME_IDX_W-1:0] byteIdx;
   logic frameStart;
   logic frameEnd;
   logic frameErr;
   logic crcOk;

   // command to the register bank
   logic cmdValid;
   logic cmdWrite;
   regAddrT cmdAddr;
   logic [7:0] cmdCount;
   regDataT cmdData;
   logic regBusy;

   // read words into the reply queue
   logic pushValid;
   regAddrT pushAddr;
   regDataT pushData;
   logic queueFull;

   gmiiFrameRx gmiiFrameRx_i
   (
      .PHY_RXCLK(PHY_RXCLK),
      .rst(rst),
      .PHY_RXD(PHY_RXD),
      .PHY_RXCTL_RXDV(PHY_RXCTL_RXDV),
      .PHY_RXER(PHY_RXER),
      .frameByte(frameByte),
      .byteValid(byteValid),
      .byteIdx(byteIdx),
      .frameStart(frameStart),
      .frameEnd(frameEnd),
      .frameErr(frameErr)
   );

   ethCrcCheck ethCrcCheck_i
   (
      .PHY_RXCLK(PHY_RXCLK),
      .rst(rst),
      .frameByte(frameByte),
      .byteValid(byteValid),
      .frameStart(frameStart),
      .frameEnd(frameEnd),
      .crcOk(crcOk)
   );

   udpCmdParser udpCmdParser_i
   (
      .PHY_RXCLK(PHY_RXCLK),
      .rst(rst),
      .frameByte(frameByte),
      .byteValid(byteValid),
      .byteIdx(byteIdx),
      .frameStart(frameStart),
      .frameEnd(frameEnd),
      .frameErr(frameErr),
      .crcOk(crcOk),
      .regBusy(regBusy),
      .cmdValid(cmdValid),
      .cmdWrite(cmdWrite),
      .cmdAddr(cmdAddr),
      .cmdCount(cmdCount),
      .cmdData(cmdData)
   );

   regBank regBank_i
   (
      .PHY_RXCLK(PHY_RXCLK),
      .rst(rst),
      .cmdValid(cmdValid),
      .cmdWrite(cmdWrite),
      .cmdAddr(cmdAddr),
      .cmdCount(cmdCount),
      .cmdData(cmdData),
      .queueFull(queueFull),
      .regBusy(regBusy),
      .pushValid(pushValid),
      .pushAddr(pushAddr),
      .pushData(pushData)
   );

   replyCreditQueue replyCreditQueue_i
   (
      .PHY_RXCLK(PHY_RXCLK),
      .rst(rst),
      .pushValid(pushValid),
      .pushAddr(pushAddr),
      .pushData(pushData),
      .queueFull(queueFull),
      .replyCredit(replyCredit),
      .replyValid(replyValid),
      .replyAddr(replyAddr),
      .replyData(replyData)
   );

endmodule

// ==== test/rtfCmdRx_chk.sv ====
module rtfCmdRx_chk import regCmdPkg::*;
(
   input logic                PHY_RXCLK,
   input logic                rst,
   input logic                replyValid,
   input logic                replyCredit,
   input logic [CREDIT_W-1:0] creditCnt
);

   // credits held by the queue, counted from its own ports
   int wordsSent;
   int creditsBack;

   always_ff @(posedge PHY_RXCLK)
   begin
      if (rst)
      begin
         wordsSent <= 0;
         creditsBack <= 0;
      end
      else
      begin
         wordsSent <= wordsSent + int'(replyValid);
         creditsBack <= creditsBack + int'(replyCredit);
      end
   end

   // queue comes out of reset with nothing to send
   resetQuiet: assert property (@(posedge PHY_RXCLK) rst |=> !replyValid)
      else $error("replyValid high in the cycle after reset");

   // no word leaves without a credit in hand
   creditNeeded: assert property (@(posedge PHY_RXCLK) disable iff (rst)
      REPLY_CREDITS + creditsBack - wordsSent == 0 |-> !replyValid)
      else $error("replyValid high with no credit held");

   // consumer never returns more than it was given
   creditLimit: assert property (@(posedge PHY_RXCLK) disable iff (rst)
      creditCnt <= CREDIT_W'(REPLY_CREDITS))
      else $error("credit count above the reset amount");

endmodule

bind replyCreditQueue rtfCmdRx_chk rtfCmdRx_chk_i
(
   .PHY_RXCLK(PHY_RXCLK),
   .rst(rst),
   .replyValid(replyValid),
   .replyCredit(replyCredit),
   .creditCnt(creditCnt)
);

// ==== test/rtfCmdRx_tb.sv ====
module rtfCmdRx_tb import ethFramePkg::*, regCmdPkg::*;
();

   // frame kinds, only GOOD reaches the registers
   localparam int GOOD = 0;
   localparam int BIT_FLIP = 1;
   localparam int RX_ERR = 2;
   localparam int BAD_MAC = 3;
   localparam int BAD_PORT = 4;
   localparam int BAD_TYPE = 5;
   localparam int FRAME_COUNT = 34;
   localparam int CYCLE_LIMIT = FRAME_COUNT * 200 + 2000;

   logic PHY_RXCLK;
   logic rst;
   logic [7:0] PHY_RXD;
   logic PHY_RXCTL_RXDV;
   logic PHY_RXER;
   logic replyCredit;
   logic replyValid;
   regAddrT replyAddr;
   regDataT replyData;

   regDataT model [REG_COUNT];
   regAddrT expAddrQ[$];
   regDataT expDataQ[$];
   int usedCredits = 0;
   int returnedCredits = 0;
   int repliesSeen = 0;
   int cycleCount = 0;
   logic holdCredits = 1'b0;

   rtfCmdRx rtfCmdRx_i
   (
      .PHY_RXCLK(PHY_RXCLK),
      .rst(rst),
      .PHY_RXD(PHY_RXD),
      .PHY_RXCTL_RXDV(PHY_RXCTL_RXDV),
      .PHY_RXER(PHY_RXER),
      .replyCredit(replyCredit),
      .replyValid(replyValid),
      .replyAddr(replyAddr),
      .replyData(replyData)
   );

   initial
   begin
      PHY_RXCLK = 1'b0;
      forever #50 PHY_RXCLK = ~PHY_RXCLK;
   end

   task automatic failRun(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1, "run stopped on the first failure");
   endtask

   task automatic checkAddr(input regAddrT got, input regAddrT exp);
      if (got !== exp)
         failRun($sformatf("** Error at time %0t: reply address %h, expected %h",
            $time, got, exp));
   endtask

   task automatic checkData(input regDataT got, input regDataT exp);
      if (got !== exp)
         failRun($sformatf("** Error at time %0t: reply data %h, expected %h",
            $time, got, exp));
   endtask

   task automatic checkCount(input int got, input int exp);
      if (got != exp)
         failRun($sformatf("** Error at time %0t: %0d replies with credits held, expected %0d",
            $time, got, exp));
   endtask

   // reflected CRC-32 over the frame body, result already inverted
   function automatic logic [31:0] ethFcs(input logic [7:0] frame[$]);
      logic [31:0] r;
      r = 32'hFFFF_FFFF;
      foreach (frame[i])
      begin
         r = r ^ {24'h0, frame[i]};
         for (int b = 0; b < 8; b++)
            r = r[0] ? (r >> 1) ^ 32'hEDB8_8320 : r >> 1;
      end
      return ~r;
   endfunction

   // register model, reads queue up the words the DUT must return
   function automatic void modelCmd(input logic write, input regAddrT addr, input int count,
      input regDataT data);
      regAddrT a;
      for (int i = 0; i < count; i++)
      begin
         a = addr + regAddrT'(i);
         if (write && a < REG_COUNT)
            model[a[REG_IDX_W-1:0]] = data;
         else if (!write)
         begin
            expAddrQ.push_back(a);
            expDataQ.push_back(a < REG_COUNT ? model[a[REG_IDX_W-1:0]] : '0);
         end
      end
   endfunction

   task automatic driveByte(input logic [7:0] b, input logic er);
      @(posedge PHY_RXCLK);
      PHY_RXD <= b;
      PHY_RXCTL_RXDV <= 1'b1;
      PHY_RXER <= er;
   endtask

   task automatic sendFrame(input logic [7:0] flags, input regAddrT addr, input int count,
      input regDataT data, input int kind);
      logic [7:0] fb[$];
      logic [335:0] hdr;
      logic [79:0] cmd;
      logic [31:0] fcs;
      logic [15:0] payLen;
      payLen = flags[FLAG_WRITE] ? 16'(CMD_HDR_BYTES + 8) : 16'(CMD_HDR_BYTES);
      if (kind == GOOD)
         modelCmd(flags[FLAG_WRITE], addr, count, data);
      // ethernet, IPv4 with zero checksum, UDP
      hdr = {BOARD_MAC, 48'h0200_0000_0001, ETHERTYPE_IPV4,
         8'h45, 8'h00, payLen + 16'd28, 16'h0000, 16'h4000, 8'h40, IP_PROTO_UDP, 16'h0000,
         32'hC0A8_2E01, BOARD_IP,
         16'd5000, CMD_PORT, payLen + 16'd8, 16'h0000};
      cmd = {flags, 8'(count), addr[7:0], addr[15:8], addr[23:16], addr[31:24],
         4'h0, addr[35:32], 24'h0};
      for (int i = 0; i < 42; i++)
         fb.push_back(hdr[335 - 8*i -: 8]);
      for (int i = 0; i < CMD_HDR_BYTES; i++)
         fb.push_back(cmd[79 - 8*i -: 8]);
      if (flags[FLAG_WRITE])
         for (int i = 0; i < 8; i++)
            fb.push_back(data[8*i +: 8]);
      if (kind == BAD_MAC)
         fb[0] = fb[0] ^ 8'h01;
      if (kind == BAD_TYPE)
         fb[OFS_ETHERTYPE + 1] = fb[OFS_ETHERTYPE + 1] ^ 8'h01;
      if (kind == BAD_PORT)
         fb[OFS_DST_PORT + 1] = fb[OFS_DST_PORT + 1] ^ 8'h01;
      fcs = ethFcs(fb);
      for (int i = 0; i < 4; i++)
         fb.push_back(fcs[8*i +: 8]);
      // damage the first data byte after the FCS is fixed
      if (kind == BIT_FLIP)
         fb[OFS_CMD + CMD_HDR_BYTES] = fb[OFS_CMD + CMD_HDR_BYTES] ^ 8'h04;
      for (int i = 0; i < 7; i++)
         driveByte(PREAMBLE_BYTE, 1'b0);
      driveByte(SFD_BYTE, 1'b0);
      foreach (fb[i])
         driveByte(fb[i], kind == RX_ERR && i == OFS_CMD + 1);
      @(posedge PHY_RXCLK);
      PHY_RXCTL_RXDV <= 1'b0;
      PHY_RXD <= 8'h00;
      PHY_RXER <= 1'b0;
   endtask

   // idle gap, then all replies in before the next frame
   task automatic frameGap();
      repeat (12) @(posedge PHY_RXCLK);
      while (expAddrQ.size() != 0)
         @(posedge PHY_RXCLK);
   endtask

   task automatic writeReg(input regAddrT addr, input regDataT data, input int kind);
      sendFrame(8'h01, addr, 1, data, kind);
      frameGap();
   endtask

   task automatic readRegs(input regAddrT addr, input int count);
      sendFrame(8'h00, addr, count, '0, GOOD);
      frameGap();
   endtask

   always @(posedge PHY_RXCLK)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= CYCLE_LIMIT)
         failRun($sformatf("timeout after %0d cycles, %0d replies still expected",
            cycleCount, expAddrQ.size()));
   end

   // every reply must match the oldest expected word
   always @(posedge PHY_RXCLK)
   begin
      if (!rst && replyValid)
      begin
         if (expAddrQ.size() == 0)
            failRun("a reply arrived that no command asked for");
         else
         begin
            checkAddr(replyAddr, expAddrQ.pop_front());
            checkData(replyData, expDataQ.pop_front());
            usedCredits <= usedCredits + 1;
            repliesSeen <= repliesSeen + 1;
         end
      end
   end

   // one credit back per word, after 0 to 7 cycles
   initial
   begin
      int delay;
      replyCredit = 1'b0;
      forever
      begin
         @(posedge PHY_RXCLK);
         if (!holdCredits && returnedCredits != usedCredits)
         begin
            delay = $urandom_range(7, 0);
            repeat (delay) @(posedge PHY_RXCLK);
            replyCredit <= 1'b1;
            returnedCredits++;
            @(posedge PHY_RXCLK);
            replyCredit <= 1'b0;
         end
      end
   end

   initial
   begin
      regAddrT addrs [8];
      int startSeen;
      PHY_RXD = 8'h00;
      PHY_RXCTL_RXDV = 1'b0;
      PHY_RXER = 1'b0;
      rst = 1'b1;
      void'($urandom(32'h3986));
      foreach (model[i])
         model[i] = '0;
      repeat (4) @(posedge PHY_RXCLK);
      rst <= 1'b0;
      repeat (4) @(posedge PHY_RXCLK);

      // write then single reads
      for (int i = 0; i < 8; i++)
      begin
         addrs[i] = regAddrT'(i * 8 + $urandom_range(7, 0));
         writeReg(addrs[i], {$urandom, $urandom}, GOOD);
      end
      for (int i = 0; i < 8; i++)
         readRegs(addrs[i], 1);

      // bursts under random credit return
      for (int i = 0; i < 4; i++)
         readRegs(regAddrT'($urandom_range(56, 0)), $urandom_range(MAX_READ_WORDS, 2));

      // bad CRC and RXER leave the old value
      writeReg(addrs[1], {$urandom, $urandom}, BIT_FLIP);
      readRegs(addrs[1], 1);
      writeReg(addrs[2], {$urandom, $urandom}, RX_ERR);
      readRegs(addrs[2], 1);

      // frames for someone else
      writeReg(addrs[3], {$urandom, $urandom}, BAD_MAC);
      writeReg(addrs[3], {$urandom, $urandom}, BAD_PORT);
      writeReg(addrs[3], {$urandom, $urandom}, BAD_TYPE);
      readRegs(addrs[3], 1);

      // addresses past the store
      writeReg(regAddrT'(64), {$urandom, $urandom}, GOOD);
      writeReg(36'h8_0000_0005, {$urandom, $urandom}, GOOD);
      readRegs(regAddrT'(62), 4);
      readRegs(36'h8_0000_0005, 1);
      readRegs(regAddrT'(5), 1);

      // burst of 8 with credits held back
      // one edge so the last reply shows up in the used count
      @(posedge PHY_RXCLK);
      while (returnedCredits != usedCredits)
         @(posedge PHY_RXCLK);
      holdCredits = 1'b1;
      startSeen = repliesSeen;
      sendFrame(8'h00, regAddrT'(16), 8, '0, GOOD);
      repeat (40) @(posedge PHY_RXCLK);
      checkCount(repliesSeen - startSeen, REPLY_CREDITS);
      holdCredits = 1'b0;
      frameGap();

      // late stray replies still hit the compare process
      repeat (20) @(posedge PHY_RXCLK);
      $display("Test OK");
      $finish;
   end

endmodule

// ==== rtfCmdRx.f ====
rtl/ethFramePkg.sv
rtl/regCmdPkg.sv
rtl/gmiiFrameRx.sv
rtl/ethCrcCheck.sv
rtl/udpCmdParser.sv
rtl/regBank.sv
rtl/replyCreditQueue.sv
rtl/rtfCmdRx.sv
test/rtfCmdRx_chk.sv
test/rtfCmdRx_tb.sv

// ==== Makefile ====
TOP := rtfCmdRx_tb
SRCS := $(shell grep -v '^+' rtfCmdRx.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/V$(TOP): rtfCmdRx.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f rtfCmdRx.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
